// File: common/switch_pkg.sv
package switch_pkg;

    localparam int NUM_PORTS   = 4;
    localparam int NUM_BANKS   = NUM_PORTS;   // one bank per ingress port
    localparam int PAGES       = 16;
    localparam int PAGE_WORDS  = 8;
    localparam int CREDITS     = 4;
    localparam int NUM_PRIO    = 2;
    localparam int QUEUE_DEPTH = NUM_BANKS * PAGES;
    localparam int NUM_QUEUES  = NUM_PORTS * NUM_PRIO;
    localparam int QADDR_W     = $clog2(QUEUE_DEPTH);

    // header word layout
    localparam int DEST_LSB = 0;
    localparam int PRIO_BIT = 3;
    localparam int TAG_LSB  = 8;

    typedef logic [15:0] word_t;

    typedef logic [$clog2(NUM_PORTS)-1:0] port_t;

    typedef logic [$clog2(NUM_BANKS)-1:0] bank_t;

    typedef logic [$clog2(PAGES)-1:0] page_t;

    typedef logic [$clog2(PAGE_WORDS)-1:0] len_t;   // word count minus one

    typedef logic prio_t;   // 1 is high

    typedef logic [2:0] credit_t;

    // word address inside a bank, page then offset
    typedef logic [$bits(page_t)+$bits(len_t)-1:0] addr_t;

    typedef logic [$clog2(NUM_QUEUES)-1:0] qidx_t;   // {dest, prio}

endpackage

// File: common/bank_if.sv
interface bank_if;

    logic              alloc_req;
    logic              wr_en;
    switch_pkg::addr_t wr_addr;
    switch_pkg::word_t wr_data;

    switch_pkg::page_t alloc_page;   // top of the free stack
    logic              alloc_ok;
    switch_pkg::word_t rd_data;      // one cycle after rd_en

    logic              rd_en;
    switch_pkg::addr_t rd_addr;
    logic              free_en;
    switch_pkg::page_t free_page;

    modport writer (
        output alloc_req, wr_en, wr_addr, wr_data,
        input  alloc_page, alloc_ok
    );

    modport bank (
        input  alloc_req, wr_en, wr_addr, wr_data,
        input  rd_en, rd_addr, free_en, free_page,
        output alloc_page, alloc_ok, rd_data
    );

    modport reader (
        output rd_en, rd_addr, free_en, free_page,
        input  rd_data
    );

endinterface

// File: common/desc_if.sv
interface desc_if;

    logic              vld;    // single-cycle push
    switch_pkg::port_t dest;
    switch_pkg::prio_t prio;
    switch_pkg::bank_t bank;
    switch_pkg::page_t page;
    switch_pkg::len_t  len;

    modport src (
        output vld, dest, prio, bank, page, len
    );

    modport dst (
        input  vld, dest, prio, bank, page, len
    );

endinterface

// File: buffer/buffer_bank.sv
module buffer_bank (
    input logic  clk,
    input logic  rst_n,
    bank_if.bank bus
);

    switch_pkg::word_t mem [switch_pkg::PAGES * switch_pkg::PAGE_WORDS];
    switch_pkg::page_t stack [switch_pkg::PAGES];
    logic [$clog2(switch_pkg::PAGES+1)-1:0] sp;   // number of free pages
    switch_pkg::page_t top;
    logic pop;

    assign top            = switch_pkg::page_t'(sp - 1'b1);
    assign bus.alloc_ok   = (sp != '0);
    assign bus.alloc_page = stack[top];
    assign pop            = bus.alloc_req && bus.alloc_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sp <= switch_pkg::PAGES[$bits(sp)-1:0];
            for (int i = 0; i < switch_pkg::PAGES; i++) begin
                stack[i] <= switch_pkg::page_t'(i);
            end
        end else begin
            if (pop && bus.free_en) begin
                stack[top] <= bus.free_page;   // swap in place
            end else if (pop) begin
                sp <= sp - 1'b1;
            end else if (bus.free_en) begin
                stack[switch_pkg::page_t'(sp)] <= bus.free_page;
                sp <= sp + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.wr_en) begin
            mem[bus.wr_addr] <= bus.wr_data;
        end
        if (bus.rd_en) begin
            bus.rd_data <= mem[bus.rd_addr];
        end
    end

endmodule

// File: rtl/write_dispatch.sv
module write_dispatch (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [switch_pkg::NUM_PORTS-1:0]              wr_sop,
    input  logic [switch_pkg::NUM_PORTS-1:0]              wr_eop,
    input  logic [switch_pkg::NUM_PORTS-1:0]              wr_vld,
    input  switch_pkg::word_t [switch_pkg::NUM_PORTS-1:0] wr_data,
    output logic [switch_pkg::NUM_PORTS-1:0]              full,
    bank_if.writer                                        banks [switch_pkg::NUM_BANKS],
    desc_if.src                                           desc
);

    logic [switch_pkg::NUM_PORTS-1:0] alloc_ok;
    switch_pkg::page_t alloc_page [switch_pkg::NUM_PORTS];
    switch_pkg::page_t cur_page [switch_pkg::NUM_PORTS];
    switch_pkg::len_t  cur_off [switch_pkg::NUM_PORTS];
    switch_pkg::port_t cur_dest [switch_pkg::NUM_PORTS];
    switch_pkg::prio_t cur_prio [switch_pkg::NUM_PORTS];
    switch_pkg::page_t page_q [switch_pkg::NUM_PORTS];
    switch_pkg::len_t  cnt_q [switch_pkg::NUM_PORTS];   // words written so far
    switch_pkg::port_t dest_q [switch_pkg::NUM_PORTS];
    switch_pkg::prio_t prio_q [switch_pkg::NUM_PORTS];
    logic [switch_pkg::NUM_PORTS-1:0] pend_vld;
    switch_pkg::port_t pend_dest [switch_pkg::NUM_PORTS];
    switch_pkg::prio_t pend_prio [switch_pkg::NUM_PORTS];
    switch_pkg::page_t pend_page [switch_pkg::NUM_PORTS];
    switch_pkg::len_t  pend_len [switch_pkg::NUM_PORTS];
    logic [switch_pkg::NUM_PORTS-1:0] grant;

    // ingress port i always writes into bank i
    for (genvar i = 0; i < switch_pkg::NUM_PORTS; i++) begin : g_port
        assign alloc_ok[i]   = banks[i].alloc_ok;
        assign alloc_page[i] = banks[i].alloc_page;
        assign cur_page[i]   = wr_sop[i] ? alloc_page[i] : page_q[i];
        assign cur_off[i]    = wr_sop[i] ? '0 : cnt_q[i];
        assign cur_dest[i]   = wr_sop[i] ?
            wr_data[i][switch_pkg::DEST_LSB +: $bits(switch_pkg::port_t)] : dest_q[i];
        assign cur_prio[i]   = wr_sop[i] ? wr_data[i][switch_pkg::PRIO_BIT] : prio_q[i];

        assign banks[i].alloc_req = wr_vld[i] && wr_sop[i];
        assign banks[i].wr_en     = wr_vld[i];
        assign banks[i].wr_addr   = {cur_page[i], cur_off[i]};
        assign banks[i].wr_data   = wr_data[i];
    end

    assign grant = pend_vld & (~pend_vld + 1'b1);   // lowest port first

    always_comb begin
        desc.vld  = |pend_vld;
        desc.dest = '0;
        desc.prio = '0;
        desc.bank = '0;
        desc.page = '0;
        desc.len  = '0;
        for (int i = 0; i < switch_pkg::NUM_PORTS; i++) begin
            if (grant[i]) begin
                desc.dest = pend_dest[i];
                desc.prio = pend_prio[i];
                desc.bank = switch_pkg::bank_t'(i);
                desc.page = pend_page[i];
                desc.len  = pend_len[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full     <= '0;
            pend_vld <= '0;
        end else begin
            full <= ~alloc_ok;   // lags the stack by a cycle
            for (int i = 0; i < switch_pkg::NUM_PORTS; i++) begin
                if (wr_vld[i] && wr_eop[i]) begin
                    pend_vld[i] <= 1'b1;
                end else if (grant[i]) begin
                    pend_vld[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < switch_pkg::NUM_PORTS; i++) begin
            if (wr_vld[i]) begin
                page_q[i] <= cur_page[i];
                cnt_q[i]  <= cur_off[i] + 1'b1;
                dest_q[i] <= cur_dest[i];
                prio_q[i] <= cur_prio[i];
                if (wr_eop[i]) begin
                    pend_dest[i] <= cur_dest[i];
                    pend_prio[i] <= cur_prio[i];
                    pend_page[i] <= cur_page[i];
                    pend_len[i]  <= cur_off[i];   // last offset is count minus one
                end
            end
        end
    end

endmodule

// File: rtl/read_scheduler.sv
module read_scheduler (
    input  logic                                          clk,
    input  logic                                          rst_n,
    desc_if.dst                                           desc,
    bank_if.reader                                        banks [switch_pkg::NUM_BANKS],
    input  logic [switch_pkg::NUM_PORTS-1:0]              credit_ret,
    output logic [switch_pkg::NUM_PORTS-1:0]              rd_sop,
    output logic [switch_pkg::NUM_PORTS-1:0]              rd_eop,
    output logic [switch_pkg::NUM_PORTS-1:0]              rd_vld,
    output switch_pkg::word_t [switch_pkg::NUM_PORTS-1:0] rd_data
);

    typedef enum logic {IDLE, STREAM} state_t;

    state_t state;
    switch_pkg::bank_t q_bank [switch_pkg::NUM_QUEUES][switch_pkg::QUEUE_DEPTH];
    switch_pkg::page_t q_page [switch_pkg::NUM_QUEUES][switch_pkg::QUEUE_DEPTH];
    switch_pkg::len_t  q_len [switch_pkg::NUM_QUEUES][switch_pkg::QUEUE_DEPTH];
    logic [switch_pkg::QADDR_W:0] wr_ptr [switch_pkg::NUM_QUEUES];
    logic [switch_pkg::QADDR_W:0] rd_ptr [switch_pkg::NUM_QUEUES];
    logic [switch_pkg::NUM_QUEUES-1:0] q_nempty;
    switch_pkg::credit_t credit [switch_pkg::NUM_PORTS];
    switch_pkg::port_t last_port;   // also the port being streamed
    switch_pkg::bank_t cur_bank;
    switch_pkg::page_t cur_page;
    switch_pkg::len_t  cur_len;
    switch_pkg::len_t  cur_off;
    switch_pkg::bank_t out_bank;
    switch_pkg::word_t bank_rd [switch_pkg::NUM_BANKS];
    switch_pkg::qidx_t push_q;
    switch_pkg::qidx_t sel_q;
    logic sel_found;
    logic rd_issue;
    logic rd_last;

    assign push_q   = {desc.dest, desc.prio};
    assign rd_issue = (state == STREAM) && (credit[last_port] != '0);
    assign rd_last  = rd_issue && (cur_off == cur_len);

    always_comb begin
        for (int q = 0; q < switch_pkg::NUM_QUEUES; q++) begin
            q_nempty[q] = (wr_ptr[q] != rd_ptr[q]);
        end
    end

    // round robin after last_port, high priority queue first
    always_comb begin
        switch_pkg::port_t p;
        sel_found = 1'b0;
        sel_q     = '0;
        for (int k = 1; k <= switch_pkg::NUM_PORTS; k++) begin
            p = switch_pkg::port_t'(last_port + k);
            if (!sel_found && credit[p] != '0 &&
                (q_nempty[{p, 1'b1}] || q_nempty[{p, 1'b0}])) begin
                sel_found = 1'b1;
                sel_q     = {p, q_nempty[{p, 1'b1}]};
            end
        end
    end

    for (genvar b = 0; b < switch_pkg::NUM_BANKS; b++) begin : g_bank
        assign banks[b].rd_en     = rd_issue && (cur_bank == b);
        assign banks[b].rd_addr   = {cur_page, cur_off};
        assign banks[b].free_en   = rd_last && (cur_bank == b);
        assign banks[b].free_page = cur_page;
        assign bank_rd[b]         = banks[b].rd_data;
    end

    assign rd_data = {switch_pkg::NUM_PORTS{bank_rd[out_bank]}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            last_port <= '1;   // port 0 is served first
            rd_vld    <= '0;
            rd_sop    <= '0;
            rd_eop    <= '0;
            for (int q = 0; q < switch_pkg::NUM_QUEUES; q++) begin
                wr_ptr[q] <= '0;
                rd_ptr[q] <= '0;
            end
            for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
                credit[p] <= switch_pkg::CREDITS[$bits(switch_pkg::credit_t)-1:0];
            end
        end else begin
            if (desc.vld) begin
                wr_ptr[push_q] <= wr_ptr[push_q] + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (sel_found) begin
                        rd_ptr[sel_q] <= rd_ptr[sel_q] + 1'b1;
                        last_port     <= sel_q[$bits(sel_q)-1:1];
                        state         <= STREAM;
                    end
                end
                STREAM: begin
                    if (rd_last) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
                credit[p] <= credit[p] + switch_pkg::credit_t'(credit_ret[p])
                           - switch_pkg::credit_t'(rd_issue && last_port == p);
            end
            rd_vld <= '0;
            rd_sop <= '0;
            rd_eop <= '0;
            if (rd_issue) begin
                rd_vld[last_port] <= 1'b1;
                rd_sop[last_port] <= (cur_off == '0);
                rd_eop[last_port] <= rd_last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (desc.vld) begin
            q_bank[push_q][wr_ptr[push_q][switch_pkg::QADDR_W-1:0]] <= desc.bank;
            q_page[push_q][wr_ptr[push_q][switch_pkg::QADDR_W-1:0]] <= desc.page;
            q_len[push_q][wr_ptr[push_q][switch_pkg::QADDR_W-1:0]]  <= desc.len;
        end
        if (state == IDLE && sel_found) begin
            cur_bank <= q_bank[sel_q][rd_ptr[sel_q][switch_pkg::QADDR_W-1:0]];
            cur_page <= q_page[sel_q][rd_ptr[sel_q][switch_pkg::QADDR_W-1:0]];
            cur_len  <= q_len[sel_q][rd_ptr[sel_q][switch_pkg::QADDR_W-1:0]];
            cur_off  <= '0;
        end else if (rd_issue) begin
            cur_off <= cur_off + 1'b1;
        end
        if (rd_issue) begin
            out_bank <= cur_bank;   // selects read data next cycle
        end
    end

endmodule

// File: rtl/switch_top.sv
module switch_top (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [switch_pkg::NUM_PORTS-1:0]              wr_sop,
    input  logic [switch_pkg::NUM_PORTS-1:0]              wr_eop,
    input  logic [switch_pkg::NUM_PORTS-1:0]              wr_vld,
    input  switch_pkg::word_t [switch_pkg::NUM_PORTS-1:0] wr_data,
    output logic [switch_pkg::NUM_PORTS-1:0]              full,
    input  logic [switch_pkg::NUM_PORTS-1:0]              credit_ret,
    output logic [switch_pkg::NUM_PORTS-1:0]              rd_sop,
    output logic [switch_pkg::NUM_PORTS-1:0]              rd_eop,
    output logic [switch_pkg::NUM_PORTS-1:0]              rd_vld,
    output switch_pkg::word_t [switch_pkg::NUM_PORTS-1:0] rd_data
);

    bank_if bank_bus [switch_pkg::NUM_BANKS] ();
    desc_if desc_bus ();

    write_dispatch u_write_dispatch (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .full    (full),
        .banks   (bank_bus),
        .desc    (desc_bus)
    );

    read_scheduler u_read_scheduler (
        .clk        (clk),
        .rst_n      (rst_n),
        .desc       (desc_bus),
        .banks      (bank_bus),
        .credit_ret (credit_ret),
        .rd_sop     (rd_sop),
        .rd_eop     (rd_eop),
        .rd_vld     (rd_vld),
        .rd_data    (rd_data)
    );

    for (genvar b = 0; b < switch_pkg::NUM_BANKS; b++) begin : g_bank
        buffer_bank u_buffer_bank (
            .clk   (clk),
            .rst_n (rst_n),
            .bus   (bank_bus[b])
        );
    end

endmodule

// File: sim/switch_assert.sv
module switch_assert (
    input logic                             clk,
    input logic                             rst_n,
    input logic [switch_pkg::NUM_PORTS-1:0] wr_sop,
    input logic [switch_pkg::NUM_PORTS-1:0] wr_vld,
    input logic [switch_pkg::NUM_PORTS-1:0] full,
    input logic [switch_pkg::NUM_PORTS-1:0] credit_ret,
    input logic [switch_pkg::NUM_PORTS-1:0] rd_sop,
    input logic [switch_pkg::NUM_PORTS-1:0] rd_eop,
    input logic [switch_pkg::NUM_PORTS-1:0] rd_vld
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;
    int avail [switch_pkg::NUM_PORTS];   // sender credit as the receiver sees it

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
                avail[p] <= switch_pkg::CREDITS;
            end
        end else begin
            for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
                avail[p] <= avail[p] + int'(credit_ret[p]) - int'(rd_vld[p]);
            end
        end
    end

    for (genvar p = 0; p < switch_pkg::NUM_PORTS; p++) begin : g_port
        a_frame_vld: assert property (@(posedge clk) disable iff (!rst_n)
            (rd_sop[p] || rd_eop[p]) |-> rd_vld[p])
        else begin
            fail_count++;
            $error("port %0d: rd_sop or rd_eop without rd_vld", p);
        end

        a_credit: assert property (@(posedge clk) disable iff (!rst_n)
            rd_vld[p] |-> (avail[p] > 0))
        else begin
            fail_count++;
            $error("port %0d: word sent with no credit left", p);
        end

        a_sop_full: assert property (@(posedge clk) disable iff (!rst_n)
            (wr_vld[p] && wr_sop[p]) |-> !full[p])
        else begin
            fail_count++;
            $error("port %0d: ingress sop while full", p);
        end
    end

endmodule

bind switch_top switch_assert u_switch_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_sop     (wr_sop),
    .wr_vld     (wr_vld),
    .full       (full),
    .credit_ret (credit_ret),
    .rd_sop     (rd_sop),
    .rd_eop     (rd_eop),
    .rd_vld     (rd_vld)
);

// File: sim/tb_switch.sv
module tb_switch;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk;
    logic rst_n;
    logic [switch_pkg::NUM_PORTS-1:0] wr_sop;
    logic [switch_pkg::NUM_PORTS-1:0] wr_eop;
    logic [switch_pkg::NUM_PORTS-1:0] wr_vld;
    logic [switch_pkg::NUM_PORTS-1:0] full;
    logic [switch_pkg::NUM_PORTS-1:0] credit_ret;
    logic [switch_pkg::NUM_PORTS-1:0] rd_sop;
    logic [switch_pkg::NUM_PORTS-1:0] rd_eop;
    logic [switch_pkg::NUM_PORTS-1:0] rd_vld;
    switch_pkg::word_t [switch_pkg::NUM_PORTS-1:0] wr_data;
    switch_pkg::word_t [switch_pkg::NUM_PORTS-1:0] rd_data;

    logic [63:0]  cmd_op [64];
    logic [127:0] cmd_test [64];
    int           cmd_arg [64][6];
    int           n_cmds;
    logic [127:0] test_name;
    logic [127:0] pkt_test [256];
    switch_pkg::word_t exp_word [256][switch_pkg::PAGE_WORDS];
    int pkt_src [256];
    int pkt_dest [256];
    int pkt_prio [256];
    int pkt_len [256];
    int pkt_seq [256];   // position in the vector file
    int arr_seq [256];   // position in arrival order
    logic [255:0] pkt_known;
    logic [255:0] pkt_got;
    int order_tag [256];
    int n_loaded;
    int n_got;
    int n_seq;
    int last_seq [32];   // per {src, dest, prio} stream
    logic [switch_pkg::NUM_PORTS-1:0] hold;
    logic [switch_pkg::NUM_PORTS-1:0] active;
    logic [switch_pkg::NUM_PORTS-1:0] in_pkt;
    int cur_tx [switch_pkg::NUM_PORTS];
    int tx_idx [switch_pkg::NUM_PORTS];
    int gap [switch_pkg::NUM_PORTS];
    int scan [switch_pkg::NUM_PORTS];
    int cur_rx [switch_pkg::NUM_PORTS];
    int rx_idx [switch_pkg::NUM_PORTS];
    int owed [switch_pkg::NUM_PORTS];
    logic [1:0] pipe [switch_pkg::NUM_PORTS];   // two-cycle credit delay
    int errors;
    int checks;
    int cycles;
    int limit;
    int total_words;
    int seed;

    switch_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_sop     (wr_sop),
        .wr_eop     (wr_eop),
        .wr_vld     (wr_vld),
        .wr_data    (wr_data),
        .full       (full),
        .credit_ret (credit_ret),
        .rd_sop     (rd_sop),
        .rd_eop     (rd_eop),
        .rd_vld     (rd_vld),
        .rd_data    (rd_data)
    );

    always #10 clk = ~clk;

    task automatic make_packet(input int src, input int dest, input int prio,
                               input int tag, input int len);
        pkt_src[tag]   = src;
        pkt_dest[tag]  = dest;
        pkt_prio[tag]  = prio;
        pkt_len[tag]   = len;
        pkt_seq[tag]   = n_seq;
        pkt_test[tag]  = test_name;
        pkt_known[tag] = 1'b1;
        n_seq++;
        total_words += len;
        exp_word[tag][0] = switch_pkg::word_t'((tag << switch_pkg::TAG_LSB)
            | (prio << switch_pkg::PRIO_BIT) | (dest << switch_pkg::DEST_LSB));
        for (int w = 1; w < len; w++) begin
            exp_word[tag][w] = switch_pkg::word_t'($random(seed));
        end
    endtask

    task automatic load_vectors(output logic ok);
        int fd;
        int code;
        int n;
        int a [6];
        logic [63:0] op;
        logic [8*128-1:0] rest;
        fd = $fopen("sim/switch_vectors.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    code = $fgets(rest, fd);
                end else if (op == "test") begin
                    code = $fscanf(fd, "%s", test_name);
                end else begin
                    if (op == "pkt") n = 5;
                    else if (op == "burst") n = 6;
                    else if (op == "full" || op == "before") n = 2;
                    else n = 1;
                    for (int i = 0; i < n; i++) begin
                        code = $fscanf(fd, "%d", a[i]);
                        cmd_arg[n_cmds][i] = a[i];
                    end
                    cmd_op[n_cmds]   = op;
                    cmd_test[n_cmds] = test_name;
                    n_cmds++;
                    if (op == "pkt") begin
                        make_packet(a[0], a[1], a[2], a[3], a[4]);
                    end else if (op == "burst") begin
                        for (int k = 0; k < a[5]; k++) begin
                            make_packet(a[0], a[1], a[2], a[3] + k, a[4]);
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_word(input int p);
        int t;
        int key;
        if (rd_sop[p]) begin
            if (in_pkt[p]) begin
                errors++;
                $display("port %0d: new packet started before the last one ended", p);
            end
            t = rd_data[p][switch_pkg::TAG_LSB +: 8];
            cur_rx[p] = t;
            rx_idx[p] = 0;
            in_pkt[p] = 1'b1;
            if (!pkt_known[t] || pkt_got[t]) begin
                errors++;
                $display("port %0d: unexpected packet with tag %0d", p, t);
            end
            checks++;
            assert (pkt_dest[t] == p) else begin
                errors++;
                $display("CHECK FAILED %0s tag %0d port: expected %0d actual %0d",
                         pkt_test[t], t, pkt_dest[t], p);
            end
        end
        if (!in_pkt[p]) begin
            errors++;
            $display("port %0d: word received outside a packet", p);
        end else begin
            t = cur_rx[p];
            checks++;
            assert (rd_data[p] == exp_word[t][rx_idx[p] % switch_pkg::PAGE_WORDS]) else begin
                errors++;
                $display("CHECK FAILED %0s tag %0d word %0d: expected %h actual %h",
                         pkt_test[t], t, rx_idx[p],
                         exp_word[t][rx_idx[p] % switch_pkg::PAGE_WORDS], rd_data[p]);
            end
            checks++;
            assert (rd_eop[p] == (rx_idx[p] == pkt_len[t] - 1)) else begin
                errors++;
                $display("CHECK FAILED %0s tag %0d eop at word %0d: expected %0d actual %0d",
                         pkt_test[t], t, rx_idx[p], rx_idx[p] == pkt_len[t] - 1, rd_eop[p]);
            end
            if (rd_eop[p]) begin
                in_pkt[p]  = 1'b0;
                pkt_got[t] = 1'b1;
                arr_seq[t] = n_got;
                n_got++;
                key = pkt_src[t] * 8 + pkt_dest[t] * 2 + pkt_prio[t];
                checks++;
                assert (pkt_seq[t] > last_seq[key]) else begin
                    errors++;
                    $display("CHECK FAILED %0s tag %0d order: expected after %0d actual %0d",
                             pkt_test[t], t, last_seq[key], pkt_seq[t]);
                end
                last_seq[key] = pkt_seq[t];
            end
            rx_idx[p]++;
        end
    endtask

    // ingress drivers, one packet at a time per port with a gap after each
    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
                wr_sop[p] = 1'b0;
                wr_eop[p] = 1'b0;
                wr_vld[p] = 1'b0;
                if (!active[p] && gap[p] > 0) begin
                    gap[p]--;
                end else if (!active[p]) begin
                    while (scan[p] < n_loaded && pkt_src[order_tag[scan[p]]] != p) begin
                        scan[p]++;
                    end
                    if (scan[p] < n_loaded && !full[p]) begin
                        active[p] = 1'b1;
                        cur_tx[p] = order_tag[scan[p]];
                        tx_idx[p] = 0;
                        scan[p]++;
                    end
                end
                if (active[p]) begin
                    wr_vld[p]  = 1'b1;
                    wr_sop[p]  = (tx_idx[p] == 0);
                    wr_eop[p]  = (tx_idx[p] == pkt_len[cur_tx[p]] - 1);
                    wr_data[p] = exp_word[cur_tx[p]][tx_idx[p]];
                    tx_idx[p]++;
                    if (wr_eop[p]) begin
                        active[p] = 1'b0;
                        gap[p]    = 4;
                    end
                end
            end
        end
    end

    // egress sinks and scoreboard
    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
                owed[p] += pipe[p][1];
                pipe[p] = {pipe[p][0], rd_vld[p]};
                credit_ret[p] = !hold[p] && owed[p] > 0;
                if (credit_ret[p]) begin
                    owed[p]--;
                end
                if (rd_vld[p]) begin
                    check_word(p);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles with %0d of %0d packets delivered",
                     cycles, n_got, n_loaded);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        logic ok;
        int count;
        int afails;
        clk = 1'b0;
        rst_n = 1'b0;
        wr_sop = '0;
        wr_eop = '0;
        wr_vld = '0;
        wr_data = '0;
        credit_ret = '0;
        hold = '0;
        active = '0;
        in_pkt = '0;
        pkt_known = '0;
        pkt_got = '0;
        test_name = "none";
        seed = 37;
        limit = 1000;
        for (int i = 0; i < 32; i++) begin
            last_seq[i] = -1;
        end
        for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
            gap[p]  = 0;
            scan[p] = 0;
            owed[p] = 0;
            pipe[p] = '0;
        end
        load_vectors(ok);
        if (!ok) begin
            $display("cannot open the vector file sim/switch_vectors.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            limit = 40 * total_words + 200;
            repeat (4) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            @(posedge clk);
            for (int c = 0; c < n_cmds; c++) begin
                if (cmd_op[c] == "pkt" || cmd_op[c] == "burst") begin
                    count = (cmd_op[c] == "burst") ? cmd_arg[c][5] : 1;
                    for (int k = 0; k < count; k++) begin
                        order_tag[n_loaded] = cmd_arg[c][3] + k;
                        n_loaded++;
                    end
                end else begin
                    @(posedge clk);
                    if (cmd_op[c] == "hold") begin
                        hold[cmd_arg[c][0]] = 1'b1;
                    end else if (cmd_op[c] == "release") begin
                        hold[cmd_arg[c][0]] = 1'b0;
                    end else if (cmd_op[c] == "wait") begin
                        repeat (cmd_arg[c][0]) @(posedge clk);
                    end else if (cmd_op[c] == "full") begin
                        checks++;
                        assert (full[cmd_arg[c][0]] == cmd_arg[c][1][0]) else begin
                            errors++;
                            $display("CHECK FAILED %0s full[%0d]: expected %0d actual %0d",
                                     cmd_test[c], cmd_arg[c][0], cmd_arg[c][1],
                                     full[cmd_arg[c][0]]);
                        end
                    end else if (cmd_op[c] != "before") begin
                        errors++;
                        $display("unknown command %0s in the vector file", cmd_op[c]);
                    end
                end
            end
            while (n_got < n_loaded) begin
                @(posedge clk);
            end
            repeat (10) @(posedge clk);
            checks++;
            assert (full == '0) else begin
                errors++;
                $display("CHECK FAILED final full: expected 0 actual %b", full);
            end
            for (int c = 0; c < n_cmds; c++) begin
                if (cmd_op[c] == "before") begin
                    checks++;
                    assert (arr_seq[cmd_arg[c][0]] < arr_seq[cmd_arg[c][1]]) else begin
                        errors++;
                        $display("CHECK FAILED %0s tag %0d before tag %0d: expected < %0d actual %0d",
                                 cmd_test[c], cmd_arg[c][0], cmd_arg[c][1],
                                 arr_seq[cmd_arg[c][1]], arr_seq[cmd_arg[c][0]]);
                    end
                end
            end
            afails = dut0.u_switch_assert.fail_count;
            $display("checks %0d, check errors %0d, assertion failures %0d, packets %0d of %0d",
                     checks, errors, afails, n_got, n_loaded);
            if (errors == 0 && afails == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

// File: sim/switch_vectors.txt
# pkt src dest prio tag len | burst src dest prio first_tag len count | wait cycles
# hold port | release port | full port level | before tag tag | test name
test basic
pkt 0 1 0 1 3
pkt 1 2 1 2 8
pkt 2 3 0 3 1
pkt 3 0 1 4 5
wait 60
test order
pkt 0 2 0 5 4
pkt 0 2 0 6 2
pkt 0 2 0 7 6
wait 60
test priority
hold 3
pkt 2 3 0 10 4
wait 30
pkt 2 3 0 11 3
pkt 2 3 0 12 2
pkt 1 3 1 13 5
pkt 1 3 1 14 1
wait 80
release 3
before 14 11
wait 60
test backpressure
hold 2
pkt 1 2 0 20 8
wait 40
release 2
wait 40
test fullness
hold 1
burst 0 1 0 30 2 20
wait 200
full 0 1
release 1
wait 100
test mixed
pkt 0 3 1 60 6
pkt 1 0 0 61 7
pkt 2 1 1 62 2
pkt 3 2 0 63 8
pkt 0 2 0 64 3
pkt 1 1 1 65 1
pkt 2 0 0 66 4
pkt 3 3 1 67 5

// File: flist.f
common/switch_pkg.sv
common/bank_if.sv
common/desc_if.sv
buffer/buffer_bank.sv
rtl/write_dispatch.sv
rtl/read_scheduler.sv
rtl/switch_top.sv
sim/switch_assert.sv
sim/tb_switch.sv

// File: Bender.yml
package:
  name: switch

sources:
  - common/switch_pkg.sv
  - common/bank_if.sv
  - common/desc_if.sv
  - buffer/buffer_bank.sv
  - rtl/write_dispatch.sv
  - rtl/read_scheduler.sv
  - rtl/switch_top.sv
  - target: test
    files:
      - sim/switch_assert.sv
      - sim/tb_switch.sv
